// ==== all.f ====
verilog/lm80c_mem_pkg.sv
verilog/rom_loader.sv
verilog/cpu_bus_port.sv
verilog/ram_eraser.sv
verilog/mem_arbiter.sv
verilog/byte_ram.sv
verilog/lm80c_mem_top.sv
testbench/tb_lm80c_mem.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass decided from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timescale 1ns/1ps -Wno-fatal -f all.f --top-module tb_lm80c_mem \
	-o tb_lm80c_mem > build.log 2>&1 \
	&& ./obj_dir/tb_lm80c_mem > sim.log 2>&1 \
	|| echo "Build or simulation ended with an error, see build.log and sim.log"
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== testbench/tb_lm80c_mem.sv ====
// LM80C memory front end testbench
module tb_lm80c_mem;
	timeunit 1ns;
	timeprecision 1ps;

	// DUT inputs
	logic                      clk_cpu;
	logic                      rst_n;
	logic                      dl_active;
	lm80c_mem_pkg::dl_index_t  dl_index;
	logic                      dl_wr;
	lm80c_mem_pkg::cpu_addr_t  dl_addr;
	lm80c_mem_pkg::byte_t      dl_data;
	logic                      cpu_req;
	logic                      cpu_we;
	lm80c_mem_pkg::cpu_addr_t  cpu_addr;
	lm80c_mem_pkg::byte_t      cpu_wdata;
	logic                      rom_enable;
	logic                      erase_trigger;
	// DUT outputs
	logic                      cpu_ack;
	lm80c_mem_pkg::byte_t      cpu_rdata;
	logic                      rom_loaded;
	logic                      erasing;
	logic                      cpu_reset;

	// Reference memory with written flags, both banks
	lm80c_mem_pkg::byte_t model_mem [lm80c_mem_pkg::RAM_WORDS];
	bit                   model_valid [lm80c_mem_pkg::RAM_WORDS];

	integer seed;
	int     checks;

	// Status lines that a wait can watch
	typedef enum int {watch_ack, watch_loaded, watch_erasing, watch_reset} watch_t;

	lm80c_mem_top lm80c_mem_top_inst (
		.clk_cpu(clk_cpu), .rst_n(rst_n),
		.dl_active(dl_active), .dl_index(dl_index), .dl_wr(dl_wr),
		.dl_addr(dl_addr), .dl_data(dl_data),
		.cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata), .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
		.rom_enable(rom_enable), .erase_trigger(erase_trigger),
		.rom_loaded(rom_loaded), .erasing(erasing), .cpu_reset(cpu_reset)
	);

	// 8 ns clock
	initial begin
		clk_cpu = 1'b0;
		forever #4 clk_cpu = ~clk_cpu;
	end

	// ====================
	// Helpers
	// ====================

	task automatic stop_on_failure();
		$display("Something failed");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s (got %h, expected %h)",
				$time, what, actual, expected);
			stop_on_failure();
		end
	endtask

	function automatic logic sample_status(input watch_t sel);
		case (sel)
			watch_ack:     sample_status = cpu_ack;
			watch_loaded:  sample_status = rom_loaded;
			watch_erasing: sample_status = erasing;
			default:       sample_status = cpu_reset;
		endcase
	endfunction

	// Step one cycle, land just after the edge
	task automatic next_cycle();
		@(posedge clk_cpu);
		#1;
	endtask

	// Poll a status line once per cycle, give up after limit cycles
	task automatic wait_level(input watch_t sel, input logic level, input int limit,
			input string what);
		int n;
		n = 0;
		while (sample_status(sel) !== level) begin
			if (n >= limit) begin
				$display("Timeout at %0t ns: %s did not happen within %0d cycles",
					$time, what, limit);
				stop_on_failure();
			end
			next_cycle();
			n++;
		end
	endtask

	// Bank choice as the CPU memory map defines it
	function automatic lm80c_mem_pkg::phys_addr_t map_addr(input logic rom_en,
			input lm80c_mem_pkg::cpu_addr_t addr);
		if (rom_en && addr < lm80c_mem_pkg::ROM_LIMIT)
			map_addr = {lm80c_mem_pkg::ROM_BANK, addr};
		else
			map_addr = {lm80c_mem_pkg::RAM_BANK, addr};
	endfunction

	// Full four-phase transfer
	task automatic cpu_access(input logic we, input lm80c_mem_pkg::cpu_addr_t addr,
			input lm80c_mem_pkg::byte_t wdata, output lm80c_mem_pkg::byte_t rdata);
		cpu_req   = 1'b1;
		cpu_we    = we;
		cpu_addr  = addr;
		cpu_wdata = wdata;
		wait_level(watch_ack, 1'b1, 200, "CPU ack");
		rdata   = cpu_rdata;
		cpu_req = 1'b0;
		wait_level(watch_ack, 1'b0, 20, "CPU ack release");
	endtask

	// One strobe plus the idle gap the host keeps
	task automatic download_byte(input lm80c_mem_pkg::cpu_addr_t addr,
			input lm80c_mem_pkg::byte_t data);
		dl_wr   = 1'b1;
		dl_addr = addr;
		dl_data = data;
		next_cycle();
		dl_wr = 1'b0;
		next_cycle();
	endtask

	// Read through the CPU port and compare with the model where it is known
	task automatic read_and_compare(input logic rom_en, input lm80c_mem_pkg::cpu_addr_t addr,
			input string what);
		lm80c_mem_pkg::phys_addr_t phys;
		lm80c_mem_pkg::byte_t      rd;
		rom_enable = rom_en;
		phys       = map_addr(rom_en, addr);
		cpu_access(1'b0, addr, 8'h00, rd);
		if (model_valid[phys])
			check_value(16'(rd), 16'(model_mem[phys]), what);
	endtask

	// ====================
	// Stimulus
	// ====================

	initial begin
		lm80c_mem_pkg::cpu_addr_t  addr;
		lm80c_mem_pkg::cpu_addr_t  pend_addr;
		lm80c_mem_pkg::byte_t      data;
		lm80c_mem_pkg::byte_t      rd;
		lm80c_mem_pkg::phys_addr_t phys;
		lm80c_mem_pkg::cpu_addr_t  probe_q [$];
		logic                      we;
		int                        i;

		seed          = 32'h4821;
		checks        = 0;
		rst_n         = 1'b0;
		dl_active     = 1'b0;
		dl_index      = '0;
		dl_wr         = 1'b0;
		dl_addr       = '0;
		dl_data       = '0;
		cpu_req       = 1'b0;
		cpu_we        = 1'b0;
		cpu_addr      = '0;
		cpu_wdata     = '0;
		rom_enable    = 1'b1;
		erase_trigger = 1'b0;
		repeat (4) @(posedge clk_cpu);
		#1;
		rst_n = 1'b1;

		// Reset state, CPU held
		check_value(16'(cpu_ack), 16'd0, "cpu_ack after reset");
		check_value(16'(erasing), 16'd0, "erasing after reset");
		check_value(16'(rom_loaded), 16'd0, "rom_loaded after reset");
		check_value(16'(cpu_reset), 16'd1, "cpu_reset after reset");

		// Request stays pending while no ROM is present
		pend_addr = 16'($random(seed)) & 16'h7fff;
		cpu_req   = 1'b1;
		cpu_we    = 1'b0;
		cpu_addr  = pend_addr;
		for (i = 0; i < 50; i++) begin
			next_cycle();
			check_value(16'(cpu_ack), 16'd0, "no ack while ROM missing");
		end

		// ROM image over index 0, sequential offsets
		dl_active = 1'b1;
		dl_index  = lm80c_mem_pkg::ROM_INDEX;
		next_cycle();
		for (i = 0; i < 32768; i++) begin
			addr = 16'(i);
			data = 8'($random(seed));
			model_mem[{lm80c_mem_pkg::ROM_BANK, addr}]   = data;
			model_valid[{lm80c_mem_pkg::ROM_BANK, addr}] = 1'b1;
			download_byte(addr, data);
		end
		dl_active = 1'b0;
		wait_level(watch_loaded, 1'b1, 10, "rom_loaded rise");
		wait_level(watch_reset, 1'b0, 10, "cpu_reset release");

		// Pending read now completes from bank 0
		wait_level(watch_ack, 1'b1, 50, "pending CPU ack");
		check_value(16'(cpu_rdata), 16'(model_mem[{lm80c_mem_pkg::ROM_BANK, pend_addr}]),
			"pending ROM read");
		cpu_req = 1'b0;
		wait_level(watch_ack, 1'b0, 20, "pending ack release");
		for (i = 0; i < 64; i++)
			read_and_compare(1'b1, 16'($random(seed)) & 16'h7fff, "ROM image read");

		// Index 1 stream lands nowhere
		dl_active = 1'b1;
		dl_index  = 8'd1;
		next_cycle();
		for (i = 0; i < 64; i++) begin
			addr = 16'($random(seed)) & 16'h7fff;
			probe_q.push_back(addr);
			download_byte(addr, 8'($random(seed)));
		end
		dl_active = 1'b0;
		next_cycle();
		check_value(16'(rom_loaded), 16'd1, "rom_loaded after index 1 stream");
		while (probe_q.size() > 0)
			read_and_compare(1'b1, probe_q.pop_front(), "read after ignored stream");

		// ====================
		// Random CPU traffic
		// ====================

		// Narrow address window so reads hit earlier writes
		for (i = 0; i < 600; i++) begin
			rom_enable = 1'($random(seed));
			we         = 1'($random(seed));
			addr       = 16'($random(seed)) & 16'h80ff;
			data       = 8'($random(seed));
			phys       = map_addr(rom_enable, addr);
			cpu_access(we, addr, data, rd);
			if (we) begin
				model_mem[phys]   = data;
				model_valid[phys] = 1'b1;
			end else if (model_valid[phys]) begin
				check_value(16'(rd), 16'(model_mem[phys]), "random traffic read");
			end
		end

		// ====================
		// Erase
		// ====================

		// Nonzero marks over bank 1, both ends included
		probe_q.push_back(16'h0000);
		probe_q.push_back(16'hffff);
		for (i = 0; i < 30; i++)
			probe_q.push_back(16'($random(seed)));
		rom_enable = 1'b0;
		for (i = 0; i < probe_q.size(); i++) begin
			data = 8'($random(seed)) | 8'h01;
			phys = map_addr(1'b0, probe_q[i]);
			cpu_access(1'b1, probe_q[i], data, rd);
			model_mem[phys]   = data;
			model_valid[phys] = 1'b1;
		end

		erase_trigger = 1'b1;
		next_cycle();
		erase_trigger = 1'b0;
		check_value(16'(erasing), 16'd1, "erasing after trigger");
		wait_level(watch_reset, 1'b1, 5, "cpu_reset during erase");
		// Whole work bank becomes the fill byte
		for (i = 0; i < 65536; i++) begin
			model_mem[{lm80c_mem_pkg::RAM_BANK, 16'(i)}]   = lm80c_mem_pkg::ERASE_VALUE;
			model_valid[{lm80c_mem_pkg::RAM_BANK, 16'(i)}] = 1'b1;
		end
		wait_level(watch_erasing, 1'b0, 70000, "end of erase");
		wait_level(watch_reset, 1'b0, 10, "cpu_reset release after erase");
		while (probe_q.size() > 0)
			read_and_compare(1'b0, probe_q.pop_front(), "marked bank 1 read after erase");
		for (i = 0; i < 100; i++)
			read_and_compare(1'b0, 16'($random(seed)), "bank 1 read after erase");
		for (i = 0; i < 100; i++)
			read_and_compare(1'b1, 16'($random(seed)) & 16'h7fff, "ROM read after erase");

		// Report
		if (checks > 0) begin
			$display("Checks done: %0d", checks);
			$display("Everything OK");
			$finish;
		end else begin
			$display("No check ran");
			stop_on_failure();
		end
	end

endmodule

// ==== verilog/byte_ram.sv ====
// Synchronous byte RAM
module byte_ram (
	input  logic                      clk_cpu,
	input  logic                      ram_we,
	input  lm80c_mem_pkg::phys_addr_t ram_addr,
	input  lm80c_mem_pkg::byte_t      ram_wdata,
	output lm80c_mem_pkg::byte_t      ram_rdata
);

	// ====================
	// Storage
	// ====================

	// Bank 0 in the lower half, bank 1 in the upper half
	lm80c_mem_pkg::byte_t mem [lm80c_mem_pkg::RAM_WORDS];

	// Single port, one-cycle read
	always_ff @(posedge clk_cpu) begin
		if (ram_we)
			mem[ram_addr] <= ram_wdata;
		// Old contents come back on a write cycle
		ram_rdata <= mem[ram_addr];
	end

endmodule

// ==== verilog/cpu_bus_port.sv ====
// CPU bus handshake port
module cpu_bus_port (
	input  logic                      clk_cpu,
	input  logic                      rst_n,
	// CPU side, four-phase req/ack
	input  logic                      cpu_req,
	input  logic                      cpu_we,
	input  lm80c_mem_pkg::cpu_addr_t  cpu_addr,
	input  lm80c_mem_pkg::byte_t      cpu_wdata,
	input  logic                      rom_enable,
	output logic                      cpu_ack,
	output lm80c_mem_pkg::byte_t      cpu_rdata,
	// Arbiter side
	output logic                      cpu_acc_req,
	output logic                      cpu_acc_we,
	output lm80c_mem_pkg::phys_addr_t cpu_acc_addr,
	output lm80c_mem_pkg::byte_t      cpu_acc_wdata,
	input  logic                      cpu_grant,
	input  lm80c_mem_pkg::byte_t      ram_rdata
);

	// Handshake phases
	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_data,
		st_ack
	} port_state_t;

	port_state_t state;

	// Registered request
	logic                     we_q;
	logic                     bank_q;
	lm80c_mem_pkg::cpu_addr_t addr_q;
	lm80c_mem_pkg::byte_t     wdata_q;
	// Latched read data
	lm80c_mem_pkg::byte_t     rdata_q;

	// ====================
	// Phase FSM
	// ====================

	always_ff @(posedge clk_cpu) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				// Wait for the CPU to ask
				st_idle: if (cpu_req) state <= st_req;
				// Hold the access until the arbiter takes it
				st_req:  if (cpu_grant) state <= st_data;
				// RAM answers one cycle after grant
				st_data: state <= st_ack;
				// Release once the CPU drops its request
				st_ack:  if (!cpu_req) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// Request capture, bank picked at this point
	always_ff @(posedge clk_cpu) begin
		if (state == st_idle && cpu_req) begin
			we_q    <= cpu_we;
			addr_q  <= cpu_addr;
			wdata_q <= cpu_wdata;
			// Low 32K shows the ROM while it is switched in
			if (rom_enable && (cpu_addr < lm80c_mem_pkg::ROM_LIMIT))
				bank_q <= lm80c_mem_pkg::ROM_BANK;
			else
				bank_q <= lm80c_mem_pkg::RAM_BANK;
		end
	end

	// Read data latch
	always_ff @(posedge clk_cpu) begin
		if (state == st_data && !we_q)
			rdata_q <= ram_rdata;
	end

	// ====================
	// Outputs
	// ====================

	assign cpu_ack   = (state == st_ack);
	assign cpu_rdata = rdata_q;

	// Access presented to the arbiter
	assign cpu_acc_req   = (state == st_req);
	assign cpu_acc_we    = we_q;
	assign cpu_acc_addr  = {bank_q, addr_q};
	assign cpu_acc_wdata = wdata_q;

endmodule

// ==== verilog/lm80c_mem_pkg.sv ====
// LM80C memory front end definitions
package lm80c_mem_pkg;

	// ====================
	// Widths
	// ====================

	// Data bus width
	localparam int BYTE_W = 8;
	// CPU bus address width
	localparam int CPU_ADDR_W = 16;
	// Bank bit plus 16-bit offset
	localparam int PHYS_ADDR_W = CPU_ADDR_W + 1;
	// Host download index width
	localparam int DL_INDEX_W = 8;

	// ====================
	// Types
	// ====================

	// One data byte
	typedef logic [BYTE_W-1:0] byte_t;
	// Address as seen on the CPU bus
	typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
	// RAM address, bank bit on top
	typedef logic [PHYS_ADDR_W-1:0] phys_addr_t;
	// Index of a download stream
	typedef logic [DL_INDEX_W-1:0] dl_index_t;

	// ====================
	// Memory map
	// ====================

	// Download stream that carries the system ROM
	localparam dl_index_t ROM_INDEX = 8'd0;

	// First CPU address past the ROM window
	localparam cpu_addr_t ROM_LIMIT = 16'h8000;

	// Bank 0 holds the 32K ROM image
	localparam logic ROM_BANK = 1'b0;
	// Bank 1 holds the 64K work RAM
	localparam logic RAM_BANK = 1'b1;

	// Fill byte for the work RAM
	localparam byte_t ERASE_VALUE = 8'h00;

	// Depth covering both banks
	localparam int RAM_WORDS = 1 << PHYS_ADDR_W;

endpackage

// ==== verilog/lm80c_mem_top.sv ====
// LM80C memory front end top
module lm80c_mem_top (
	input  logic                     clk_cpu,
	input  logic                     rst_n,
	// Host download
	input  logic                     dl_active,
	input  lm80c_mem_pkg::dl_index_t dl_index,
	input  logic                     dl_wr,
	input  lm80c_mem_pkg::cpu_addr_t dl_addr,
	input  lm80c_mem_pkg::byte_t     dl_data,
	// CPU handshake
	input  logic                     cpu_req,
	input  logic                     cpu_we,
	input  lm80c_mem_pkg::cpu_addr_t cpu_addr,
	input  lm80c_mem_pkg::byte_t     cpu_wdata,
	output logic                     cpu_ack,
	output lm80c_mem_pkg::byte_t     cpu_rdata,
	// Control and status
	input  logic                     rom_enable,
	input  logic                     erase_trigger,
	output logic                     rom_loaded,
	output logic                     erasing,
	output logic                     cpu_reset
);

	// Loader to arbiter
	logic                      load_wr;
	lm80c_mem_pkg::phys_addr_t load_addr;
	lm80c_mem_pkg::byte_t      load_data;
	logic                      downloading;
	// CPU port to arbiter
	logic                      cpu_acc_req;
	logic                      cpu_acc_we;
	lm80c_mem_pkg::phys_addr_t cpu_acc_addr;
	lm80c_mem_pkg::byte_t      cpu_acc_wdata;
	logic                      cpu_grant;
	// Eraser to arbiter
	logic                      erase_wr;
	lm80c_mem_pkg::phys_addr_t erase_addr;
	logic                      erase_grant;
	// RAM command and read data
	logic                      ram_we;
	lm80c_mem_pkg::phys_addr_t ram_addr;
	lm80c_mem_pkg::byte_t      ram_wdata;
	lm80c_mem_pkg::byte_t      ram_rdata;

	// ====================
	// Input side
	// ====================

	rom_loader rom_loader_inst (
		.clk_cpu(clk_cpu), .rst_n(rst_n),
		.dl_active(dl_active), .dl_index(dl_index), .dl_wr(dl_wr),
		.dl_addr(dl_addr), .dl_data(dl_data),
		.load_wr(load_wr), .load_addr(load_addr), .load_data(load_data),
		.downloading(downloading), .rom_loaded(rom_loaded)
	);

	cpu_bus_port cpu_bus_port_inst (
		.clk_cpu(clk_cpu), .rst_n(rst_n),
		.cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata), .rom_enable(rom_enable),
		.cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
		.cpu_acc_req(cpu_acc_req), .cpu_acc_we(cpu_acc_we),
		.cpu_acc_addr(cpu_acc_addr), .cpu_acc_wdata(cpu_acc_wdata),
		.cpu_grant(cpu_grant), .ram_rdata(ram_rdata)
	);

	// ====================
	// Processing
	// ====================

	ram_eraser ram_eraser_inst (
		.clk_cpu(clk_cpu), .rst_n(rst_n),
		.erase_trigger(erase_trigger), .erase_grant(erase_grant),
		.erasing(erasing), .erase_wr(erase_wr), .erase_addr(erase_addr)
	);

	mem_arbiter mem_arbiter_inst (
		.clk_cpu(clk_cpu), .rst_n(rst_n),
		.load_wr(load_wr), .load_addr(load_addr), .load_data(load_data),
		.downloading(downloading), .rom_loaded(rom_loaded),
		.erasing(erasing), .erase_wr(erase_wr), .erase_addr(erase_addr),
		.cpu_acc_req(cpu_acc_req), .cpu_acc_we(cpu_acc_we),
		.cpu_acc_addr(cpu_acc_addr), .cpu_acc_wdata(cpu_acc_wdata),
		.erase_grant(erase_grant), .cpu_grant(cpu_grant),
		.ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
		.cpu_reset(cpu_reset)
	);

	// ====================
	// Output side
	// ====================

	byte_ram byte_ram_inst (
		.clk_cpu(clk_cpu), .ram_we(ram_we), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
	);

endmodule

// ==== verilog/mem_arbiter.sv ====
// RAM access arbiter
module mem_arbiter (
	input  logic                      clk_cpu,
	input  logic                      rst_n,
	// ROM loader
	input  logic                      load_wr,
	input  lm80c_mem_pkg::phys_addr_t load_addr,
	input  lm80c_mem_pkg::byte_t      load_data,
	input  logic                      downloading,
	input  logic                      rom_loaded,
	// Eraser
	input  logic                      erasing,
	input  logic                      erase_wr,
	input  lm80c_mem_pkg::phys_addr_t erase_addr,
	// CPU port
	input  logic                      cpu_acc_req,
	input  logic                      cpu_acc_we,
	input  lm80c_mem_pkg::phys_addr_t cpu_acc_addr,
	input  lm80c_mem_pkg::byte_t      cpu_acc_wdata,
	// Grants
	output logic                      erase_grant,
	output logic                      cpu_grant,
	// RAM command
	output logic                      ram_we,
	output lm80c_mem_pkg::phys_addr_t ram_addr,
	output lm80c_mem_pkg::byte_t      ram_wdata,
	// CPU hold
	output logic                      cpu_reset
);

	// CPU may run this cycle
	logic cpu_allowed;

	// ====================
	// CPU reset
	// ====================

	// Held while the ROM is missing or the RAM is being wiped
	always_ff @(posedge clk_cpu) begin
		if (!rst_n)
			cpu_reset <= 1'b1;
		else
			cpu_reset <= !rom_loaded || erasing;
	end

	// Downloads freeze the CPU even when it is out of reset
	assign cpu_allowed = !cpu_reset && !downloading;

	// ====================
	// Selection
	// ====================

	always_comb begin
		// Idle command points at the CPU address
		erase_grant = 1'b0;
		cpu_grant   = 1'b0;
		ram_we      = 1'b0;
		ram_addr    = cpu_acc_addr;
		ram_wdata   = cpu_acc_wdata;
		if (load_wr) begin
			// Download bytes always win
			ram_we    = 1'b1;
			ram_addr  = load_addr;
			ram_wdata = load_data;
		end else if (erase_wr) begin
			ram_we      = 1'b1;
			ram_addr    = erase_addr;
			ram_wdata   = lm80c_mem_pkg::ERASE_VALUE;
			erase_grant = 1'b1;
		end else if (cpu_acc_req && cpu_allowed) begin
			// Reads use the same slot, data returns next cycle
			ram_we    = cpu_acc_we;
			cpu_grant = 1'b1;
		end
	end

endmodule

// ==== verilog/ram_eraser.sv ====
// Work RAM eraser
module ram_eraser (
	input  logic                      clk_cpu,
	input  logic                      rst_n,
	// One-cycle start pulse
	input  logic                      erase_trigger,
	// Write taken by the arbiter
	input  logic                      erase_grant,
	output logic                      erasing,
	output logic                      erase_wr,
	output lm80c_mem_pkg::phys_addr_t erase_addr
);

	// Offset inside bank 1
	lm80c_mem_pkg::cpu_addr_t offset;

	// Last offset of the bank
	logic last_offset;

	assign last_offset = (offset == '1);

	// ====================
	// Sweep
	// ====================

	always_ff @(posedge clk_cpu) begin
		if (!rst_n) begin
			erasing <= 1'b0;
			offset  <= '0;
		end else if (!erasing) begin
			// Trigger while busy falls through here and is ignored
			if (erase_trigger) begin
				erasing <= 1'b1;
				offset  <= '0;
			end
		end else if (erase_grant) begin
			// Step only when the write went in
			if (last_offset)
				erasing <= 1'b0;
			else
				offset <= offset + 1'b1;
		end
	end

	// One write request per busy cycle
	assign erase_wr   = erasing;
	assign erase_addr = {lm80c_mem_pkg::RAM_BANK, offset};

endmodule

// ==== verilog/rom_loader.sv ====
// ROM download loader
module rom_loader (
	input  logic                     clk_cpu,
	input  logic                     rst_n,
	// Host download stream
	input  logic                     dl_active,
	input  lm80c_mem_pkg::dl_index_t dl_index,
	input  logic                     dl_wr,
	input  lm80c_mem_pkg::cpu_addr_t dl_addr,
	input  lm80c_mem_pkg::byte_t     dl_data,
	// Write into bank 0
	output logic                     load_wr,
	output lm80c_mem_pkg::phys_addr_t load_addr,
	output lm80c_mem_pkg::byte_t     load_data,
	// Status
	output logic                     downloading,
	output logic                     rom_loaded
);

	// Stream activity one cycle back, for edge detection
	logic active_q;
	// Index captured when the stream opened
	lm80c_mem_pkg::dl_index_t stream_index;

	// ====================
	// Byte path
	// ====================

	// Only strobes of a ROM stream become RAM writes
	always_ff @(posedge clk_cpu) begin
		if (!rst_n) begin
			load_wr <= 1'b0;
		end else begin
			load_wr <= dl_wr && dl_active && (dl_index == lm80c_mem_pkg::ROM_INDEX);
		end
	end

	// Payload registers follow every strobe
	always_ff @(posedge clk_cpu) begin
		if (dl_wr) begin
			// ROM offset is the stream address
			load_addr <= {lm80c_mem_pkg::ROM_BANK, dl_addr};
			load_data <= dl_data;
		end
	end

	// ====================
	// Stream tracking
	// ====================

	always_ff @(posedge clk_cpu) begin
		if (!rst_n) begin
			active_q     <= 1'b0;
			stream_index <= '0;
			rom_loaded   <= 1'b0;
		end else begin
			active_q <= dl_active;
			// Stream opens
			if (dl_active && !active_q)
				stream_index <= dl_index;
			// Stream closes, flag sticks until reset
			if (!dl_active && active_q && (stream_index == lm80c_mem_pkg::ROM_INDEX))
				rom_loaded <= 1'b1;
		end
	end

	// Any stream counts, plus the trailing write still in flight
	assign downloading = dl_active || load_wr;

endmodule
